// ==== verilog.f ====
+incdir+.
rv_isa_pkg.sv
npc_ctrl_pkg.sv
pc_unit.sv
inst_decode.sv
register_file.sv
alu.sv
lsu.sv
npc.sv
tb_npc.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the testbench with verilator, run it, decide on the printed result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f verilog.f \
    --top-module tb_npc -Mdir obj_dir -o tb_npc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_npc_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== tb_npc.sv ====
`timescale 1ns/10ps
`include "npc_config.svh"

module tb_npc;
    import rv_isa_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;
    localparam logic [31:0] DATA_BASE    = 32'h8000_1000;
    // step limit for each test
    localparam int LIMIT_RESET = 10;
    localparam int LIMIT_ALU   = 60;
    localparam int LIMIT_FLOW  = 30;
    localparam int LIMIT_LOAD  = 40;
    localparam int LIMIT_STORE = 40;
    localparam int LIMIT_HALT  = 10;
    localparam int WATCHDOG_CYCLES = LIMIT_RESET + LIMIT_ALU + LIMIT_FLOW + LIMIT_LOAD
                                   + LIMIT_STORE + LIMIT_HALT + 6 * (RESET_CYCLES + 2) + 200;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] inst_addr;
    logic [31:0] inst_data = NOP_WORD;
    logic [31:0] data_addr;
    logic [31:0] data_rdata = 32'd0;
    logic [31:0] data_wdata;
    logic [3:0]  data_wmask;
    logic        data_wen;
    logic        halt;
    logic [31:0] alu_result;

    // sparse memories
    // bumping mem_gen wakes the read processes
    logic [31:0] imem [logic [31:0]];
    logic [31:0] dmem [logic [31:0]];
    int          mem_gen = 0;
    logic [31:0] prog_pc;
    // store seen at negedge and applied on the next rising edge
    logic        wr_pending = 1'b0;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_mask;
    // observed trace and expected stores
    logic [31:0] pc_trace [$];
    logic [31:0] alu_trace [$];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    logic [3:0]  st_mask [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [3:0]  exp_st_mask [$];
    logic        halted;
    int          errors = 0;
    integer      seed = 99344;

    always #(CLK_PERIOD / 2) clk = ~clk;

    npc npc_inst (
        .clk(clk), .reset(reset), .inst_addr(inst_addr), .inst_data(inst_data),
        .data_addr(data_addr), .data_rdata(data_rdata), .data_wdata(data_wdata),
        .data_wmask(data_wmask), .data_wen(data_wen), .halt(halt), .alu_result(alu_result)
    );

    // pattern for unwritten data words from the word address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return dmem.exists(a) ? dmem[a] : fill_word(a);
    endfunction

    function automatic void write_lanes(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [3:0] mask);
        logic [31:0] word;
        word = read_word(addr);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) word[8*i +: 8] = wdata[8*i +: 8];
        end
        dmem[{addr[31:2], 2'b00}] = word;
        mem_gen++;
    endfunction

    // fetch port returns a nop while reset is high
    always @(inst_addr or reset or mem_gen) begin
        inst_data = (reset || !imem.exists(inst_addr)) ? NOP_WORD : imem[inst_addr];
    end

    always @(data_addr or mem_gen) begin
        data_rdata = read_word(data_addr);
    end

    always @(negedge clk) begin
        wr_pending = data_wen && !reset;
        wr_addr    = data_addr;
        wr_data    = data_wdata;
        wr_mask    = data_wmask;
    end

    always @(posedge clk) begin
        if (wr_pending) write_lanes(wr_addr, wr_data, wr_mask);
    end

    // instruction encoders
    function automatic inst_t r_type(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
        inst_t w;
        w.r = '{funct7: 7'd0, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic inst_t i_type(input opcode_t opc, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        inst_t w;
        w.i = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic inst_t s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [11:0] imm);
        inst_t w;
        w.s = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3,
                imm_4_0: imm[4:0], opcode: store};
        return w;
    endfunction

    // bne only with the offset in bytes
    function automatic inst_t b_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [12:0] off);
        inst_t w;
        w.b = '{imm_12: off[12], imm_10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3_bne,
                imm_4_1: off[4:1], imm_11: off[11], opcode: branch};
        return w;
    endfunction

    function automatic inst_t u_type(input opcode_t opc, input logic [4:0] rd,
                                     input logic [19:0] imm);
        inst_t w;
        w.u = '{imm_31_12: imm, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic inst_t j_type(input logic [4:0] rd, input logic [20:0] off);
        inst_t w;
        w.j = '{imm_20: off[20], imm_10_1: off[10:1], imm_11: off[11],
                imm_19_12: off[19:12], rd: rd, opcode: jal};
        return w;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic void emit(input logic [31:0] w);
        imem[prog_pc] = w;
        prog_pc += 32'd4;
        mem_gen++;
    endfunction

    // lui plus addi
    // upper part rounded for the signed low half
    function automatic void load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(u_type(lui, rd, hi[19:0]));
        emit(i_type(op_imm, f3_add, rd, rd, value[11:0]));
    endfunction

    function automatic void expect_store(input logic [31:0] addr, input logic [31:0] wdata,
                                         input logic [3:0] mask);
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(wdata);
        exp_st_mask.push_back(mask);
    endfunction

    function automatic void new_program();
        imem.delete();
        dmem.delete();
        pc_trace.delete();
        alu_trace.delete();
        st_addr.delete();
        st_data.delete();
        st_mask.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        exp_st_mask.delete();
        prog_pc = `NPC_RESET_PC;
        mem_gen++;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    // one sample per cycle at negedge until halt
    task automatic run_program(input int limit);
        int steps;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < limit) begin
            @(negedge clk);
            pc_trace.push_back(inst_addr);
            alu_trace.push_back(alu_result);
            if (data_wen) begin
                st_addr.push_back(data_addr);
                st_data.push_back(data_wdata);
                st_mask.push_back(data_wmask);
            end
            halted = halt;
            steps++;
        end
        if (!halted) begin
            errors++;
            $display("ERROR: no ebreak within %0d cycles, pc is %h", limit, inst_addr);
        end
    endtask

    task automatic compare_stores();
        int n;
        if (st_addr.size() != exp_st_addr.size()) begin
            errors++;
            $display("ERROR: saw %0d stores but expected %0d", st_addr.size(),
                     exp_st_addr.size());
        end
        n = (st_addr.size() < exp_st_addr.size()) ? st_addr.size() : exp_st_addr.size();
        for (int i = 0; i < n; i++) begin
            check_word("data_addr", exp_st_addr[i], st_addr[i]);
            check_word("data_wdata", exp_st_data[i], st_data[i]);
            check_mask("data_wmask", exp_st_mask[i], st_mask[i]);
        end
    endtask

    // first word is a store that would raise data_wen if fetched during reset
    task automatic reset_state();
        new_program();
        emit(s_type(f3_sw, 5'd0, 5'd0, 12'd0));
        emit(EBREAK_WORD);
        expect_store(32'd0, 32'd0, 4'hf);
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_word("pc", `NPC_RESET_PC, inst_addr);
        check_bit("data_wen", 1'b0, data_wen);
        check_bit("halt", 1'b0, halt);
        @(posedge clk);
        #2 reset = 1'b0;
        run_program(LIMIT_RESET);
        check_word("pc", `NPC_RESET_PC, pc_trace[0]);
        compare_stores();
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] auipc_pc;
        logic [31:0] expected [9];
        a = $random(seed);
        b = $random(seed);
        r = $random(seed);
        new_program();
        emit(u_type(lui, 5'd10, DATA_BASE[31:12]));
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(r_type(f3_add, 5'd3, 5'd1, 5'd2));
        emit(r_type(f3_xor, 5'd4, 5'd1, 5'd2));
        emit(r_type(f3_or, 5'd5, 5'd1, 5'd2));
        emit(i_type(op_imm, f3_sltiu, 5'd6, 5'd1, r[11:0]));
        emit(i_type(op_imm, f3_sltiu, 5'd7, 5'd2, 12'hfff));
        auipc_pc = prog_pc;
        emit(u_type(auipc, 5'd8, r[31:12]));
        // addi into x0 whose result must vanish
        emit(i_type(op_imm, f3_add, 5'd0, 5'd1, 12'd5));
        expected = '{a, b, a + b, a ^ b, a | b,
                     (a < sext12(r[11:0])) ? 32'd1 : 32'd0,
                     (b < 32'hffff_ffff) ? 32'd1 : 32'd0,
                     auipc_pc + {r[31:12], 12'd0}, 32'd0};
        for (int k = 0; k < 9; k++) begin
            emit(s_type(f3_sw, (k == 8) ? 5'd0 : 5'(k + 1), 5'd10, 12'(4 * k)));
            expect_store(DATA_BASE + 32'(4 * k), expected[k], 4'hf);
        end
        emit(EBREAK_WORD);
        apply_reset();
        run_program(LIMIT_ALU);
        compare_stores();
        // alu output in the cycles of add through the x0 addi
        if (alu_trace.size() < 12) begin
            errors++;
            $display("ERROR: alu trace has only %0d entries", alu_trace.size());
        end else begin
            for (int k = 2; k < 8; k++) begin
                check_word("alu_result", expected[k], alu_trace[k + 3]);
            end
            check_word("alu_result", a + 32'd5, alu_trace[11]);
        end
    endtask

    task automatic control_flow();
        int path [13] = '{0, 1, 2, 3, 4, 6, 8, 9, 11, 12, 13, 14, 15};
        new_program();
        emit(i_type(op_imm, f3_add, 5'd1, 5'd0, 12'd5));
        emit(i_type(op_imm, f3_add, 5'd2, 5'd0, 12'd5));
        // equal operands fall through
        emit(b_type(5'd1, 5'd2, 13'd8));
        emit(i_type(op_imm, f3_add, 5'd3, 5'd0, 12'd7));
        // taken branch skips the next word
        emit(b_type(5'd1, 5'd0, 13'd8));
        emit(i_type(op_imm, f3_add, 5'd3, 5'd0, 12'd99));
        emit(j_type(5'd4, 21'd8));
        emit(i_type(op_imm, f3_add, 5'd3, 5'd0, 12'd55));
        emit(u_type(auipc, 5'd5, 20'd0));
        // odd offset with target bit 0 cleared
        emit(i_type(jalr, 3'b000, 5'd6, 5'd5, 12'd13));
        emit(i_type(op_imm, f3_add, 5'd3, 5'd0, 12'd66));
        emit(u_type(lui, 5'd10, DATA_BASE[31:12]));
        emit(s_type(f3_sw, 5'd3, 5'd10, 12'd0));
        emit(s_type(f3_sw, 5'd4, 5'd10, 12'd4));
        emit(s_type(f3_sw, 5'd6, 5'd10, 12'd8));
        emit(EBREAK_WORD);
        expect_store(DATA_BASE, 32'd7, 4'hf);
        expect_store(DATA_BASE + 32'd4, `NPC_RESET_PC + 32'd28, 4'hf);
        expect_store(DATA_BASE + 32'd8, `NPC_RESET_PC + 32'd40, 4'hf);
        apply_reset();
        run_program(LIMIT_FLOW);
        if (pc_trace.size() != 13) begin
            errors++;
            $display("ERROR: pc trace has %0d entries instead of 13", pc_trace.size());
        end
        for (int i = 0; i < 13 && i < pc_trace.size(); i++) begin
            check_word("pc", `NPC_RESET_PC + 32'(4 * path[i]), pc_trace[i]);
        end
        compare_stores();
    endtask

    task automatic word_and_byte_loads();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] expected [7];
        w0 = $random(seed);
        w1 = $random(seed);
        new_program();
        dmem[DATA_BASE] = w0;
        dmem[DATA_BASE + 32'd4] = w1;
        emit(u_type(lui, 5'd10, DATA_BASE[31:12]));
        emit(i_type(load, f3_lw, 5'd1, 5'd10, 12'd0));
        expected[0] = w0;
        for (int k = 0; k < 4; k++) begin
            emit(i_type(load, f3_lbu, 5'(k + 2), 5'd10, 12'(k)));
            expected[k + 1] = {24'd0, w0[8*k +: 8]};
        end
        emit(i_type(load, f3_lw, 5'd6, 5'd10, 12'd4));
        emit(i_type(load, f3_lbu, 5'd7, 5'd10, 12'd7));
        expected[5] = w1;
        expected[6] = {24'd0, w1[31:24]};
        for (int k = 0; k < 7; k++) begin
            emit(s_type(f3_sw, 5'(k + 1), 5'd10, 12'(16 + 4 * k)));
            expect_store(DATA_BASE + 32'(16 + 4 * k), expected[k], 4'hf);
        end
        emit(EBREAK_WORD);
        apply_reset();
        run_program(LIMIT_LOAD);
        compare_stores();
    endtask

    task automatic byte_stores();
        logic [31:0] v [4];
        logic [31:0] exp1;
        new_program();
        emit(u_type(lui, 5'd10, DATA_BASE[31:12]));
        for (int k = 0; k < 4; k++) begin
            v[k] = $random(seed);
            load_const(5'(k + 1), v[k]);
        end
        for (int k = 0; k < 4; k++) begin
            emit(s_type(f3_sb, 5'(k + 1), 5'd10, 12'(k)));
            expect_store(DATA_BASE + 32'(k), {4{v[k][7:0]}}, 4'b0001 << k);
        end
        // lane 2 of a word never written before
        emit(s_type(f3_sb, 5'd1, 5'd10, 12'd6));
        expect_store(DATA_BASE + 32'd6, {4{v[0][7:0]}}, 4'b0100);
        emit(EBREAK_WORD);
        apply_reset();
        run_program(LIMIT_STORE);
        compare_stores();
        exp1 = fill_word(DATA_BASE + 32'd4);
        exp1[23:16] = v[0][7:0];
        check_word("dmem word 0", {v[3][7:0], v[2][7:0], v[1][7:0], v[0][7:0]},
                   read_word(DATA_BASE));
        check_word("dmem word 1", exp1, read_word(DATA_BASE + 32'd4));
    endtask

    task automatic ebreak_halt();
        logic [31:0] ebreak_pc;
        new_program();
        emit(i_type(op_imm, f3_add, 5'd1, 5'd0, 12'd1));
        ebreak_pc = prog_pc;
        emit(EBREAK_WORD);
        emit(i_type(op_imm, f3_add, 5'd2, 5'd0, 12'd2));
        apply_reset();
        run_program(LIMIT_HALT);
        // halt first seen on the second cycle
        check_word("halt cycle", 32'd2, 32'(pc_trace.size()));
        check_word("pc", ebreak_pc, inst_addr);
        repeat (4) begin
            @(negedge clk);
            check_bit("halt", 1'b1, halt);
            check_word("pc", ebreak_pc, inst_addr);
            check_bit("data_wen", 1'b0, data_wen);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset_state();
        alu_ops();
        control_flow();
        word_and_byte_loads();
        byte_stores();
        ebreak_halt();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== npc.sv ====
`timescale 1ns/10ps

module npc (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_data,
    output logic [31:0] data_addr,
    input  logic [31:0] data_rdata,
    output logic [31:0] data_wdata,
    output logic [3:0]  data_wmask,
    output logic        data_wen,
    output logic        halt,
    output logic [31:0] alu_result
);
    import npc_ctrl_pkg::*;

    logic [31:0] pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_t     alu_op;
    wb_sel_t     wb_sel;
    npc_sel_t    npc_sel;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        reg_wen;
    logic        load_en;
    logic        load_byte;
    logic        store_en;
    logic        store_byte;
    logic        is_branch;
    logic        is_ebreak;
    logic        branch_taken;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] load_data;
    logic [31:0] wb_data;

    // fetch straight from pc
    assign inst_addr = pc;

    // ebreak stops the core and holds pc
    assign halt = is_ebreak;

    // jal is always taken, bne only on the alu flag
    assign branch_taken = !is_branch || alu_result[0];

    pc_unit pc_unit_inst (
        .clk(clk), .reset(reset), .npc_sel(npc_sel), .branch_taken(branch_taken),
        .hold(is_ebreak), .imm(imm), .rs1_val(rs1_val), .pc(pc)
    );

    inst_decode inst_decode_inst (
        .inst(inst_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm), .reg_wen(reg_wen),
        .load_en(load_en), .load_byte(load_byte), .store_en(store_en),
        .store_byte(store_byte), .is_branch(is_branch), .is_ebreak(is_ebreak),
        .wb_sel(wb_sel), .npc_sel(npc_sel)
    );

    register_file register_file_inst (
        .clk(clk), .reset(reset), .wen(reg_wen), .waddr(rd), .raddr1(rs1),
        .raddr2(rs2), .wdata(wb_data), .rdata1(rs1_val), .rdata2(rs2_val)
    );

    // operand muxes, pc for auipc and imm for i and u types
    assign alu_src1 = src1_is_pc  ? pc  : rs1_val;
    assign alu_src2 = src2_is_imm ? imm : rs2_val;

    alu alu_inst (
        .src1(alu_src1), .src2(alu_src2), .alu_op(alu_op), .result(alu_result)
    );

    lsu lsu_inst (
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .load_en(load_en),
        .load_byte(load_byte), .store_en(store_en), .store_byte(store_byte),
        .mem_rdata(data_rdata), .addr(data_addr), .wdata(data_wdata),
        .wmask(data_wmask), .wen(data_wen), .load_data(load_data)
    );

    // writeback select
    always_comb begin
        case (wb_sel)
            wb_mem:  wb_data = load_data;
            wb_pc4:  wb_data = pc + 32'd4;
            wb_imm:  wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

endmodule

// ==== lsu.sv ====
`timescale 1ns/10ps
`include "npc_config.svh"

module lsu (
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic [31:0] imm,
    input  logic        load_en,
    input  logic        load_byte,
    input  logic        store_en,
    input  logic        store_byte,
    input  logic [31:0] mem_rdata,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    output logic [3:0]  wmask,
    output logic        wen,
    output logic [31:0] load_data
);

    logic [31:0] eff_addr;
    logic [1:0]  lane;
    logic [7:0]  rd_byte;

    // effective address, rs1 + offset
    assign eff_addr = rs1_val + imm;
    assign lane     = eff_addr[1:0];

    // idle accesses point at the reset pc so memory never sees junk
    assign addr = (load_en || store_en) ? eff_addr : `NPC_RESET_PC;

    // store side
    // sb copies the low byte to every lane, mask picks the one lane
    assign wen   = store_en;
    assign wdata = store_byte ? {4{rs2_val[7:0]}} : rs2_val;
    assign wmask = !store_en  ? 4'b0000 :
                   store_byte ? (4'b0001 << lane) : 4'b1111;

    // load side
    // memory returns the aligned word
    always_comb begin
        case (lane)
            2'd0:    rd_byte = mem_rdata[7:0];
            2'd1:    rd_byte = mem_rdata[15:8];
            2'd2:    rd_byte = mem_rdata[23:16];
            default: rd_byte = mem_rdata[31:24];
        endcase
    end

    // lbu zero-extends
    assign load_data = load_byte ? {24'd0, rd_byte} : mem_rdata;

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic [31:0]           src1,
    input  logic [31:0]           src2,
    input  npc_ctrl_pkg::alu_op_t alu_op,
    output logic [31:0]           result
);
    import npc_ctrl_pkg::*;

    logic [31:0] sum;
    logic        lt_u;
    logic        ne;

    // shared adder
    // add, addi, auipc
    assign sum  = src1 + src2;

    // unsigned compare for sltiu
    assign lt_u = (src1 < src2);

    // inequality, drives the bne decision
    assign ne   = (src1 != src2);

    always_comb begin
        case (alu_op)
            alu_add:  result = sum;
            // flags land in bit 0
            alu_sltu: result = {31'd0, lt_u};
            alu_ne:   result = {31'd0, ne};
            alu_xor:  result = src1 ^ src2;
            alu_or:   result = src1 | src2;
            default:  result = 32'd0;
        endcase
    end

endmodule

// ==== register_file.sv ====
`timescale 1ns/10ps
`include "npc_config.svh"

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [`NPC_REG_COUNT];

    // single write port
    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NPC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async read ports
    // x0 reads zero whatever the array holds
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode (
    input  rv_isa_pkg::inst_t      inst,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [4:0]             rd,
    output logic [31:0]            imm,
    output npc_ctrl_pkg::alu_op_t  alu_op,
    output logic                   src1_is_pc,
    output logic                   src2_is_imm,
    output logic                   reg_wen,
    output logic                   load_en,
    output logic                   load_byte,
    output logic                   store_en,
    output logic                   store_byte,
    output logic                   is_branch,
    output logic                   is_ebreak,
    output npc_ctrl_pkg::wb_sel_t  wb_sel,
    output npc_ctrl_pkg::npc_sel_t npc_sel
);
    import rv_isa_pkg::*;
    import npc_ctrl_pkg::*;

    logic [2:0] funct3;

    // register fields line up across all formats
    assign rs1    = inst.r.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;
    assign funct3 = inst.r.funct3;

    always_comb begin
        // everything idle by default, so unknown words act as a nop
        imm         = '0;
        alu_op      = alu_add;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        reg_wen     = 1'b0;
        load_en     = 1'b0;
        load_byte   = 1'b0;
        store_en    = 1'b0;
        store_byte  = 1'b0;
        is_branch   = 1'b0;
        is_ebreak   = 1'b0;
        wb_sel      = wb_alu;
        npc_sel     = npc_seq;

        case (inst.r.opcode)
            lui: begin
                imm     = {inst.u.imm_31_12, 12'b0};
                reg_wen = 1'b1;
                wb_sel  = wb_imm;
            end
            auipc: begin
                imm         = {inst.u.imm_31_12, 12'b0};
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                reg_wen     = 1'b1;
            end
            jal: begin
                imm     = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                           inst.j.imm_11, inst.j.imm_10_1, 1'b0};
                reg_wen = 1'b1;
                wb_sel  = wb_pc4;
                npc_sel = npc_rel;
            end
            jalr: begin
                imm     = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                reg_wen = 1'b1;
                wb_sel  = wb_pc4;
                npc_sel = npc_jalr;
            end
            op_imm: begin
                imm         = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                src2_is_imm = 1'b1;
                // addi and sltiu only
                if (funct3 == f3_add) begin
                    reg_wen = 1'b1;
                end else if (funct3 == f3_sltiu) begin
                    alu_op  = alu_sltu;
                    reg_wen = 1'b1;
                end
            end
            op: begin
                // funct7 must be zero, sub and sra fall through as nop
                if (inst.r.funct7 == 7'd0) begin
                    case (funct3)
                        f3_add: reg_wen = 1'b1;
                        f3_xor: begin
                            alu_op  = alu_xor;
                            reg_wen = 1'b1;
                        end
                        f3_or: begin
                            alu_op  = alu_or;
                            reg_wen = 1'b1;
                        end
                        default: reg_wen = 1'b0;
                    endcase
                end
            end
            load: begin
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                if (funct3 == f3_lw || funct3 == f3_lbu) begin
                    load_en   = 1'b1;
                    load_byte = (funct3 == f3_lbu);
                    reg_wen   = 1'b1;
                    wb_sel    = wb_mem;
                end
            end
            store: begin
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
                if (funct3 == f3_sw || funct3 == f3_sb) begin
                    store_en   = 1'b1;
                    store_byte = (funct3 == f3_sb);
                end
            end
            branch: begin
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
                // bne compares rs1 against rs2 in the alu
                if (funct3 == f3_bne) begin
                    is_branch = 1'b1;
                    alu_op    = alu_ne;
                    npc_sel   = npc_rel;
                end
            end
            system: is_ebreak = (inst == EBREAK_WORD);
            default: is_ebreak = 1'b0;
        endcase
    end

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/10ps
`include "npc_config.svh"

module pc_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  npc_ctrl_pkg::npc_sel_t npc_sel,
    input  logic                  branch_taken,
    input  logic                  hold,
    input  logic [31:0]           imm,
    input  logic [31:0]           rs1_val,
    output logic [31:0]           pc
);
    import npc_ctrl_pkg::*;

    logic [31:0] next_pc;
    logic [31:0] jalr_target;

    // jalr target, lsb forced low
    assign jalr_target = (rs1_val + imm) & ~32'd1;

    always_comb begin
        next_pc = pc + 32'd4;
        case (npc_sel)
            // branch_taken is tied high for jal by the top level
            npc_rel:  if (branch_taken) next_pc = pc + imm;
            npc_jalr: next_pc = jalr_target;
            default:  next_pc = pc + 32'd4;
        endcase
    end

    // pc register
    // hold parks pc on ebreak until the next reset
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `NPC_RESET_PC;
        end else if (!hold) begin
            pc <= next_pc;
        end
    end

endmodule

// ==== npc_ctrl_pkg.sv ====
package npc_ctrl_pkg;

    // alu function select
    // compare ops return 0 or 1 in bit 0
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sltu = 3'd1,
        alu_ne   = 3'd2,
        alu_xor  = 3'd3,
        alu_or   = 3'd4
    } alu_op_t;

    // source of the register writeback value
    typedef enum logic [1:0] {
        // alu result, most arithmetic
        wb_alu = 2'd0,
        // load data from the lsu
        wb_mem = 2'd1,
        // link address for jal and jalr
        wb_pc4 = 2'd2,
        // raw immediate for lui
        wb_imm = 2'd3
    } wb_sel_t;

    // next pc source
    typedef enum logic [1:0] {
        // fall through to pc + 4
        npc_seq  = 2'd0,
        // pc + imm, jal and taken branches
        npc_rel  = 2'd1,
        // rs1 + imm with bit 0 cleared
        npc_jalr = 2'd2
    } npc_sel_t;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes in the implemented subset
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        system = 7'b1110011
    } opcode_t;

    // funct3 values, grouped by opcode
    localparam logic [2:0] f3_add   = 3'b000;
    localparam logic [2:0] f3_xor   = 3'b100;
    localparam logic [2:0] f3_or    = 3'b110;
    localparam logic [2:0] f3_sltiu = 3'b011;
    localparam logic [2:0] f3_lw    = 3'b010;
    localparam logic [2:0] f3_lbu   = 3'b100;
    localparam logic [2:0] f3_sw    = 3'b010;
    localparam logic [2:0] f3_sb    = 3'b000;
    localparam logic [2:0] f3_bne   = 3'b001;

    // the only system instruction handled
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // one instruction word, six format views
    // register and opcode fields sit at the same bits in every view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_t    opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_t    opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            opcode_t     opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            opcode_t    opcode;
        } j;
    } inst_t;

endpackage

// ==== npc_config.svh ====
`ifndef NPC_CONFIG_SVH
`define NPC_CONFIG_SVH

// core-wide configuration constants

// pc loaded on reset
// first fetch comes from the start of main memory
`define NPC_RESET_PC 32'h8000_0000

// integer register count for rv32i
// x0 is one of these and stays hard-wired to zero
`define NPC_REG_COUNT 32

// register index width
// follows from the count above
`define NPC_REG_AW 5

`endif
